//--- hw/rename_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// sizing constants for the rename stage
// reorder buffer depth, index width and tag width
////////////////////////////////////////////////////////////////////////////

package rename_cfg_pkg;

    // number of reorder buffer entries
    // kept a power of two so head and tail wrap on their own
    localparam int rob_depth = 16;

    // width of a reorder buffer index
    localparam int rob_idx_bits = $clog2(rob_depth);

    ////////////////////////////////////////////////////////////////////////////
    // tag encoding
    ////////////////////////////////////////////////////////////////////////////

    // one extra high bit on top of the index
    // high bit set means value lives in the register file
    localparam int rob_tag_bits = rob_idx_bits + 1;

endpackage

//--- hw/rename_types_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types for the rename stage
// rob tag type, zero tag, architectural register index type
////////////////////////////////////////////////////////////////////////////

package rename_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // reorder buffer tags
    ////////////////////////////////////////////////////////////////////////////

    // {in_regfile, rob index}
    typedef logic [rename_cfg_pkg::rob_tag_bits-1:0] rob_tag_t;

    // only the high bit set
    // operand comes from the register file
    localparam rob_tag_t zero_tag = {1'b1, {rename_cfg_pkg::rob_idx_bits{1'b0}}};

    ////////////////////////////////////////////////////////////////////////////
    // architectural registers
    ////////////////////////////////////////////////////////////////////////////

    // largest register file the design supports
    localparam int max_reg_count = 32;

    // widest register index
    // modules narrow it to their own REG_COUNT
    typedef logic [$clog2(max_reg_count)-1:0] reg_idx_t;

    // hard-wired register, never renamed
    localparam reg_idx_t zero_reg = '0;

endpackage

//--- hw/rob_rename_if.sv
////////////////////////////////////////////////////////////////////////////
// reorder buffer to map table link
// retire, allocation and squash information
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface rob_rename_if #(
    parameter int REG_COUNT = 32
);
    import rename_types_pkg::*;

    // head retiring with a destination register
    logic                         retire_valid;
    logic [$clog2(REG_COUNT)-1:0] retire_reg;
    rob_tag_t                     head_tag;
    // tag a dispatch this cycle receives
    rob_tag_t                     tail_tag;
    // dispatch accepted, rob not full
    logic                         alloc;
    logic                         squash;

    modport source (
        output retire_valid, retire_reg, head_tag, tail_tag, alloc, squash
    );

    modport sink (
        input retire_valid, retire_reg, head_tag, tail_tag, alloc, squash
    );

endinterface

//--- hw/map_table.sv
////////////////////////////////////////////////////////////////////////////
// map table
// per-register rob tag and ready bit, two operand lookup ports
// with retire override and cdb bypass
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module map_table #(
    parameter int REG_COUNT = 32
) (
    input  logic                          clock,
    input  logic                          reset,
    rob_rename_if.sink                    rob,
    input  logic [$clog2(REG_COUNT)-1:0]  rd_dispatch,
    input  logic                          cdb_valid,
    input  rename_types_pkg::rob_tag_t    cdb_tag,
    input  logic [$clog2(REG_COUNT)-1:0]  rs1_idx,
    input  logic [$clog2(REG_COUNT)-1:0]  rs2_idx,
    output rename_types_pkg::rob_tag_t    rs1_tag,
    output rename_types_pkg::rob_tag_t    rs2_tag,
    output logic                          rs1_ready,
    output logic                          rs2_ready
);
    import rename_types_pkg::*;

    localparam int reg_bits = $clog2(REG_COUNT);

    // result of one operand lookup
    typedef struct packed {
        rob_tag_t tag;
        logic     ready;
    } lookup_t;

    // table state
    rob_tag_t             map_tag [REG_COUNT];
    logic [REG_COUNT-1:0] map_ready;

    rob_tag_t             map_tag_next [REG_COUNT];
    logic [REG_COUNT-1:0] map_ready_next;

    lookup_t              rs1_res;
    lookup_t              rs2_res;

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        map_tag_next   = map_tag;
        map_ready_next = map_ready;
        if (rob.squash) begin
            // everything back to the register file
            map_tag_next   = '{default: zero_tag};
            map_ready_next = '0;
        end else begin
            // retire clear, only if no newer producer took the register
            if (rob.retire_valid && map_tag[rob.retire_reg] == rob.head_tag) begin
                map_tag_next[rob.retire_reg]   = zero_tag;
                map_ready_next[rob.retire_reg] = 1'b0;
            end
            // completion broadcast, may hit several entries
            // cleared entries hold zero tag and never match
            if (cdb_valid) begin
                for (int i = 0; i < REG_COUNT; i++) begin
                    if (map_tag_next[i] == cdb_tag) begin
                        map_ready_next[i] = 1'b1;
                    end
                end
            end
            // new producer wins over everything above
            if (rob.alloc && rd_dispatch != reg_bits'(zero_reg)) begin
                map_tag_next[rd_dispatch]   = rob.tail_tag;
                map_ready_next[rd_dispatch] = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            map_tag   <= '{default: zero_tag};
            map_ready <= '0;
        end else begin
            map_tag   <= map_tag_next;
            map_ready <= map_ready_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // operand lookup
    ////////////////////////////////////////////////////////////////////////////

    // reads state before the edge
    // retiring register reads as register file, not ready
    function automatic lookup_t lookup(input logic [reg_bits-1:0] idx);
        lookup_t res;
        logic    retiring;
        retiring = rob.retire_valid && (rob.retire_reg == idx);
        if (retiring) begin
            res.tag   = zero_tag;
            res.ready = 1'b0;
        end else begin
            res.tag   = map_tag[idx];
            // bypass a same-cycle broadcast
            res.ready = map_ready[idx] || (cdb_valid && cdb_tag == map_tag[idx]);
        end
        return res;
    endfunction

    always_comb begin
        rs1_res = lookup(rs1_idx);
        rs2_res = lookup(rs2_idx);
    end

    assign rs1_tag   = rs1_res.tag;
    assign rs1_ready = rs1_res.ready;
    assign rs2_tag   = rs2_res.tag;
    assign rs2_ready = rs2_res.ready;

endmodule

//--- hw/reorder_buffer.sv
////////////////////////////////////////////////////////////////////////////
// reorder buffer
// circular buffer of destination registers and completion flags
// allocates at the tail, retires in order from the head
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reorder_buffer #(
    parameter int REG_COUNT = 32
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          squash,
    input  logic                          dispatch_enable,
    input  logic [$clog2(REG_COUNT)-1:0]  rd_dispatch,
    input  logic                          cdb_valid,
    input  rename_types_pkg::rob_tag_t    cdb_tag,
    rob_rename_if.source                  rob,
    output logic                          rob_full,
    output logic                          retire_reg_valid
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int reg_bits = $clog2(REG_COUNT);

    // pointers wrap on their own at a power-of-two depth
    logic [rob_idx_bits-1:0] head;
    logic [rob_idx_bits-1:0] tail;
    // 0 to rob_depth inclusive
    logic [rob_idx_bits:0]   count;

    // per-entry state
    logic [reg_bits-1:0]     dest_reg [rob_depth];
    logic [rob_depth-1:0]    has_dest;
    logic [rob_depth-1:0]    complete;

    logic                    alloc;
    logic                    retire;

    ////////////////////////////////////////////////////////////////////////////
    // status and handshake-free strobes
    ////////////////////////////////////////////////////////////////////////////

    assign rob_full = (count == (rob_idx_bits + 1)'(rob_depth));

    // the only place the full test is made
    assign alloc = dispatch_enable && !rob_full;

    // pop the head once it is complete
    assign retire = (count != '0) && complete[head];

    assign retire_reg_valid = retire;

    // towards the map table
    assign rob.alloc        = alloc;
    assign rob.squash       = squash;
    assign rob.tail_tag     = {1'b0, tail};
    assign rob.head_tag     = {1'b0, head};
    // x0 destinations pop quietly
    assign rob.retire_valid = retire && has_dest[head];
    assign rob.retire_reg   = dest_reg[head];

    ////////////////////////////////////////////////////////////////////////////
    // pointers, count, completion flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            complete <= '0;
        end else begin
            // broadcast marks by index
            // zero tag on the bus names no entry
            if (cdb_valid && !cdb_tag[rob_idx_bits]) begin
                complete[cdb_tag[rob_idx_bits-1:0]] <= 1'b1;
            end
            // fresh entry starts incomplete
            if (alloc) begin
                complete[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            // count holds when one enters and one leaves
            if (alloc && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !alloc) begin
                count <= count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // entry payload
    ////////////////////////////////////////////////////////////////////////////

    // destination of each entry, written at allocation
    always_ff @(posedge clock) begin
        if (alloc) begin
            dest_reg[tail] <= rd_dispatch;
            has_dest[tail] <= (rd_dispatch != reg_bits'(zero_reg));
        end
    end

endmodule

//--- hw/rename_unit_top.sv
////////////////////////////////////////////////////////////////////////////
// rename stage top level
// reorder buffer and map table behind plain ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_unit_top #(
    parameter int REG_COUNT = 32
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          squash,
    // dispatch
    input  logic                          dispatch_enable,
    input  logic [$clog2(REG_COUNT)-1:0]  rd_dispatch,
    // source operands
    input  logic [$clog2(REG_COUNT)-1:0]  rs1_idx,
    input  logic [$clog2(REG_COUNT)-1:0]  rs2_idx,
    // common data bus
    input  logic                          cdb_valid,
    input  rename_types_pkg::rob_tag_t    cdb_tag,
    // lookup results
    output rename_types_pkg::rob_tag_t    rs1_tag,
    output logic                          rs1_ready,
    output rename_types_pkg::rob_tag_t    rs2_tag,
    output logic                          rs2_ready,
    output rename_types_pkg::rob_tag_t    dispatch_tag,
    output logic                          rob_full,
    // retire
    output logic                          retire_valid,
    output logic [$clog2(REG_COUNT)-1:0]  retire_reg
);

    rob_rename_if #(.REG_COUNT(REG_COUNT)) rob_if ();

    reorder_buffer #(
        .REG_COUNT (REG_COUNT)
    ) rob_i (
        .clock            (clock),
        .reset            (reset),
        .squash           (squash),
        .dispatch_enable  (dispatch_enable),
        .rd_dispatch      (rd_dispatch),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .rob              (rob_if.source),
        .rob_full         (rob_full),
        // retire pulse for x0 producers too, not exported
        .retire_reg_valid ()
    );

    map_table #(
        .REG_COUNT (REG_COUNT)
    ) map_i (
        .clock       (clock),
        .reset       (reset),
        .rob         (rob_if.sink),
        .rd_dispatch (rd_dispatch),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .rs1_ready   (rs1_ready),
        .rs2_ready   (rs2_ready)
    );

    // rob side strobes seen at the top
    assign dispatch_tag = rob_if.tail_tag;
    assign retire_valid = rob_if.retire_valid;
    assign retire_reg   = rob_if.retire_reg;

endmodule

//--- dv/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2.0) clock = ~clock;
    end

    // held over RESET_CYCLES rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- dv/rename_props.sv
////////////////////////////////////////////////////////////////////////////
// map table assertions, bound into every map_table
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_props #(
    parameter int REG_COUNT = 32
) (
    input logic                          clock,
    input logic                          reset,
    input logic                          squash,
    input logic                          alloc,
    input rename_types_pkg::rob_tag_t    tail_tag,
    input logic [$clog2(REG_COUNT)-1:0]  rd_dispatch,
    input logic [$clog2(REG_COUNT)-1:0]  rs1_idx,
    input logic [$clog2(REG_COUNT)-1:0]  rs2_idx,
    input rename_types_pkg::rob_tag_t    rs1_tag,
    input rename_types_pkg::rob_tag_t    rs2_tag,
    input rename_types_pkg::rob_tag_t    map_tag [REG_COUNT]
);
    import rename_types_pkg::*;

    // failed assertions so far
    int unsigned fail_count = 0;

    // register 0 never renamed
    zero_reg_lookup: assert property (@(posedge clock) disable iff (reset)
        (rs1_idx != '0 || rs1_tag == zero_tag) && (rs2_idx != '0 || rs2_tag == zero_tag))
    else begin
        fail_count++;
        $error("lookup of register 0 returned a renamed tag");
    end

    // accepted dispatch leaves the new tag in the table
    dispatch_writes_tag: assert property (@(posedge clock) disable iff (reset)
        (alloc && !squash && rd_dispatch != '0)
        |=> (map_tag[$past(rd_dispatch)] == $past(tail_tag)))
    else begin
        fail_count++;
        $error("dispatched register does not hold the allocated tag");
    end

    // flush sends every operand back to the register file
    squash_clears: assert property (@(posedge clock) disable iff (reset)
        squash |=> (rs1_tag == zero_tag && rs2_tag == zero_tag))
    else begin
        fail_count++;
        $error("lookup after squash is not the zero tag");
    end

endmodule

bind map_table rename_props #(
    .REG_COUNT (REG_COUNT)
) props_i (
    .clock       (clock),
    .reset       (reset),
    .squash      (rob.squash),
    .alloc       (rob.alloc),
    .tail_tag    (rob.tail_tag),
    .rd_dispatch (rd_dispatch),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rs1_tag     (rs1_tag),
    .rs2_tag     (rs2_tag),
    .map_tag     (map_tag)
);

//--- dv/rename_tb.sv
////////////////////////////////////////////////////////////////////////////
// rename stage testbench
// directed and random stimulus, shadow model, compare process, timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_tb;
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int reg_count       = 32;
    localparam int directed_cycles = 69;
    localparam int random_cycles   = 400;
    localparam int cycle_limit     = 2 * (4 + directed_cycles + random_cycles);

    logic           clock;
    logic           reset;
    logic           squash;
    logic           dispatch_enable;
    logic [4:0]     rd_dispatch;
    logic [4:0]     rs1_idx;
    logic [4:0]     rs2_idx;
    logic           cdb_valid;
    rob_tag_t       cdb_tag;
    rob_tag_t       rs1_tag;
    rob_tag_t       rs2_tag;
    logic           rs1_ready;
    logic           rs2_ready;
    rob_tag_t       dispatch_tag;
    logic           rob_full;
    logic           retire_valid;
    logic [4:0]     retire_reg;

    string          test_name = "reset";
    logic [31:0]    lfsr_state = 32'h9b11a4c9;
    int             cycle_count = 0;

    // shadow map table
    rob_tag_t       m_tag [reg_count];
    logic           m_ready [reg_count];
    // shadow reorder buffer
    logic [4:0]     m_dest [rob_depth];
    logic [15:0]    m_has;
    logic [15:0]    m_complete;
    logic [3:0]     m_head;
    logic [3:0]     m_tail;
    int             m_count;

    tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(4)) clock_i (
        .clock (clock),
        .reset (reset)
    );

    rename_unit_top #(.REG_COUNT(reg_count)) dut_i (
        .clock           (clock),
        .reset           (reset),
        .squash          (squash),
        .dispatch_enable (dispatch_enable),
        .rd_dispatch     (rd_dispatch),
        .rs1_idx         (rs1_idx),
        .rs2_idx         (rs2_idx),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .rs1_tag         (rs1_tag),
        .rs1_ready       (rs1_ready),
        .rs2_tag         (rs2_tag),
        .rs2_ready       (rs2_ready),
        .dispatch_tag    (dispatch_tag),
        .rob_full        (rob_full),
        .retire_valid    (retire_valid),
        .retire_reg      (retire_reg)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("ERR %s: %s expected %0h actual %0h",
                                     test_name, what, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////////////////////

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic out_bit;
        out_bit = state[0];
        state   = state >> 1;
        if (out_bit) begin
            state = state ^ 32'h80200003;
        end
        return state;
    endfunction

    // one step per bit
    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // head complete with a destination register
    function automatic logic model_retire_valid();
        return m_count != 0 && m_complete[m_head] && m_has[m_head];
    endfunction

    // {tag, ready} for one operand from the state before the edge
    function automatic logic [5:0] ref_lookup(input logic [4:0] idx);
        logic ready;
        if (model_retire_valid() && m_dest[m_head] == idx) begin
            return {zero_tag, 1'b0};
        end
        ready = m_ready[idx] || (cdb_valid && cdb_tag == m_tag[idx]);
        return {m_tag[idx], ready};
    endfunction

    // one rising edge of the shadow state
    task automatic advance_model();
        logic retire;
        logic alloc;
        if (reset || squash) begin
            for (int i = 0; i < reg_count; i++) begin
                m_tag[i]   = zero_tag;
                m_ready[i] = 1'b0;
            end
            m_head     = '0;
            m_tail     = '0;
            m_count    = 0;
            m_complete = '0;
        end else begin
            retire = m_count != 0 && m_complete[m_head];
            alloc  = dispatch_enable && m_count != rob_depth;
            // clear only if the head is still the mapped producer
            if (model_retire_valid() && m_tag[m_dest[m_head]] == {1'b0, m_head}) begin
                m_tag[m_dest[m_head]]   = zero_tag;
                m_ready[m_dest[m_head]] = 1'b0;
            end
            if (cdb_valid) begin
                for (int i = 0; i < reg_count; i++) begin
                    if (m_tag[i] == cdb_tag) begin
                        m_ready[i] = 1'b1;
                    end
                end
                if (!cdb_tag[rob_idx_bits]) begin
                    m_complete[cdb_tag[3:0]] = 1'b1;
                end
            end
            if (alloc) begin
                if (rd_dispatch != '0) begin
                    m_tag[rd_dispatch]   = {1'b0, m_tail};
                    m_ready[rd_dispatch] = 1'b0;
                end
                m_complete[m_tail] = 1'b0;
                m_dest[m_tail]     = rd_dispatch;
                m_has[m_tail]      = rd_dispatch != '0;
                m_tail             = m_tail + 1'b1;
            end
            if (retire) begin
                m_head = m_head + 1'b1;
            end
            m_count = m_count + int'(alloc) - int'(retire);
        end
    endtask

    task automatic compare_outputs();
        logic [5:0] exp1;
        logic [5:0] exp2;
        exp1 = ref_lookup(rs1_idx);
        exp2 = ref_lookup(rs2_idx);
        check_value("rs1_tag", exp1[5:1], rs1_tag);
        check_value("rs1_ready", exp1[0], rs1_ready);
        check_value("rs2_tag", exp2[5:1], rs2_tag);
        check_value("rs2_ready", exp2[0], rs2_ready);
        check_value("dispatch_tag", {1'b0, m_tail}, dispatch_tag);
        check_value("rob_full", m_count == rob_depth, rob_full);
        check_value("retire_valid", model_retire_valid(), retire_valid);
        if (model_retire_valid()) begin
            check_value("retire_reg", m_dest[m_head], retire_reg);
        end
    endtask

    // compare 1 ns before each rising edge and step the model on it
    initial begin : compare_proc
        forever begin
            @(negedge clock);
            #3;
            if (!reset) begin
                compare_outputs();
            end
            @(posedge clock);
            advance_model();
        end
    end

    initial begin : timeout_proc
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                report_failure($sformatf("timeout: run did not finish in %0d cycles",
                                         cycle_limit));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(input logic en, input logic [4:0] rd,
                               input logic [4:0] s1, input logic [4:0] s2,
                               input logic cv, input logic [3:0] ct, input logic sq);
        @(negedge clock);
        dispatch_enable = en;
        rd_dispatch     = rd;
        rs1_idx         = s1;
        rs2_idx         = s2;
        cdb_valid       = cv;
        cdb_tag         = {1'b0, ct};
        squash          = sq;
    endtask

    task automatic random_mix(input int cycles);
        logic [31:0] bits;
        for (int n = 0; n < cycles; n++) begin
            @(negedge clock);
            take_bits(1, bits);
            dispatch_enable = bits[0];
            take_bits(5, bits);
            rd_dispatch = bits[4:0];
            take_bits(5, bits);
            rs1_idx = bits[4:0];
            take_bits(5, bits);
            rs2_idx = bits[4:0];
            take_bits(1, bits);
            cdb_valid = bits[0];
            // index only so the zero tag never appears
            take_bits(4, bits);
            cdb_tag = {1'b0, bits[3:0]};
            // roughly one squash in 32 cycles
            take_bits(5, bits);
            squash = bits[4:0] == 5'd0;
        end
    endtask

    initial begin : stimulus_proc
        squash          = 1'b0;
        dispatch_enable = 1'b0;
        rd_dispatch     = '0;
        rs1_idx         = '0;
        rs2_idx         = '0;
        cdb_valid       = 1'b0;
        cdb_tag         = '0;
        wait (reset == 1'b0);

        test_name = "reset_state";
        for (int r = 0; r < reg_count / 2; r++) begin
            drive_cycle(0, 5'(2 * r), 5'(2 * r), 5'(2 * r + 1), 0, 0, 0);
        end

        // tags 0..3 to r5, r6, r0, r7
        test_name = "dispatch";
        drive_cycle(1, 5, 0, 0, 0, 0, 0);
        #2 check_value("dispatch_tag", 5'h00, dispatch_tag);
        drive_cycle(1, 6, 5, 0, 0, 0, 0);
        #2 check_value("rs1_tag", 5'h00, rs1_tag);
        drive_cycle(1, 0, 6, 5, 0, 0, 0);
        #2 check_value("dispatch_tag", 5'h02, dispatch_tag);
        drive_cycle(1, 7, 0, 6, 0, 0, 0);
        drive_cycle(0, 0, 7, 0, 0, 0, 0);
        #2 check_value("rs1_tag", 5'h03, rs1_tag);
        check_value("rs2_tag", zero_tag, rs2_tag);

        // bypass first and the stored bit one cycle later
        test_name = "broadcast";
        drive_cycle(0, 0, 6, 5, 1, 1, 0);
        #2 check_value("rs1_ready", 1, rs1_ready);
        drive_cycle(0, 0, 6, 5, 0, 0, 0);
        #2 check_value("rs1_ready", 1, rs1_ready);

        // r5 renamed to tag 4 before tag 0 retires
        test_name = "retire";
        drive_cycle(1, 5, 5, 6, 0, 0, 0);
        drive_cycle(0, 0, 5, 6, 1, 0, 0);
        #2 check_value("rs1_ready", 0, rs1_ready);
        drive_cycle(0, 0, 5, 6, 0, 0, 0);
        #2 check_value("retire_reg", 5, retire_reg);
        check_value("rs1_tag", zero_tag, rs1_tag);
        drive_cycle(0, 0, 5, 6, 0, 0, 0);
        #2 check_value("rs1_tag", 5'h04, rs1_tag);
        drive_cycle(0, 0, 7, 6, 1, 2, 0);
        drive_cycle(0, 0, 7, 6, 1, 3, 0);
        #2 check_value("retire_valid", 0, retire_valid);
        drive_cycle(0, 0, 7, 5, 0, 0, 0);
        #2 check_value("retire_valid", 1, retire_valid);
        drive_cycle(0, 0, 7, 5, 0, 0, 0);

        // 15 more dispatches fill the buffer behind the entry in flight
        test_name = "full";
        for (int i = 0; i < 15; i++) begin
            drive_cycle(1, 5'(i + 1), 5'(i), 20, 0, 0, 0);
        end
        repeat (3) begin
            drive_cycle(1, 20, 20, 1, 0, 0, 0);
            #2 check_value("rob_full", 1, rob_full);
            check_value("rs1_tag", zero_tag, rs1_tag);
        end
        drive_cycle(0, 0, 1, 2, 0, 0, 1);
        drive_cycle(0, 0, 1, 2, 0, 0, 0);
        #2 check_value("rob_full", 0, rob_full);
        check_value("rs1_tag", zero_tag, rs1_tag);
        check_value("rs2_tag", zero_tag, rs2_tag);

        // every register back on the register file
        for (int r = 0; r < reg_count / 2; r++) begin
            drive_cycle(0, 0, 5'(2 * r), 5'(2 * r + 1), 0, 0, 0);
            #2 check_value("rs1_tag", zero_tag, rs1_tag);
            check_value("rs2_tag", zero_tag, rs2_tag);
        end

        test_name = "random_mix";
        random_mix(random_cycles);

        test_name = "drain";
        drive_cycle(0, 0, 0, 0, 0, 0, 0);
        drive_cycle(0, 0, 0, 0, 0, 0, 0);
        if (dut_i.map_i.props_i.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_failure("map table assertion failed during the run");
        end
    end

endmodule

//--- verilog.f
hw/rename_cfg_pkg.sv
hw/rename_types_pkg.sv
hw/rob_rename_if.sv
hw/map_table.sv
hw/reorder_buffer.sv
hw/rename_unit_top.sv
dv/tb_clock_gen.sv
dv/rename_props.sv
dv/rename_tb.sv

//--- Bender.yml
package:
  name: rename_unit

sources:
  # packages first, then interface and RTL
  - files:
      - hw/rename_cfg_pkg.sv
      - hw/rename_types_pkg.sv
      - hw/rob_rename_if.sv
      - hw/map_table.sv
      - hw/reorder_buffer.sv
      - hw/rename_unit_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/rename_props.sv
      - dv/rename_tb.sv
